// File: verilog/bp_pkg.sv
`default_nettype none

package bp_pkg;

   ////////////////////////////////////////////////////////////////////
   // Address layout
   ////////////////////////////////////////////////////////////////////

   localparam int xlen = 32;

   // Only address bits 15..2 are kept for index, tag and target
   localparam int addr_lo  = 2;
   localparam int addr_hi  = 15;
   localparam int tgt_bits = addr_hi - addr_lo + 1;

   typedef logic [xlen-1:0] pc_t;

   // Top bit set means predict taken
   typedef enum logic [1:0] {
      strong_not_taken = 2'd0,
      weak_not_taken   = 2'd1,
      weak_taken       = 2'd2,
      strong_taken     = 2'd3
   } ctr_state_e;

   ////////////////////////////////////////////////////////////////////
   // Width helpers
   ////////////////////////////////////////////////////////////////////

   function automatic int tag_width(input int idx_len);
      return tgt_bits - idx_len;
   endfunction

   function automatic int table_depth(input int idx_len);
      return 1 << idx_len;
   endfunction

   // Stored target field from a full address
   function automatic logic [tgt_bits-1:0] compress_target(input pc_t target);
      return target[addr_hi:addr_lo];
   endfunction

   // Back to a full address with zeros above bit 15 and in bits 1..0
   function automatic pc_t expand_target(input logic [tgt_bits-1:0] field);
      return {{(xlen - addr_hi - 1){1'b0}}, field, {addr_lo{1'b0}}};
   endfunction

endpackage

`default_nettype wire

// File: verilog/bp_lookup_if.sv
`timescale 1ns/1ps
`default_nettype none

// One lookup slot carrying an address in and a prediction back
interface bp_lookup_if import bp_pkg::*; ();

   logic en;
   pc_t  pc;
   logic hit;
   pc_t  target;
   logic taken;

   modport requester (
      output en,
      output pc,
      input  hit,
      input  target,
      input  taken
   );

   modport btb_side (
      input  en,
      input  pc,
      output hit,
      output target
   );

   modport dir_side (
      input  en,
      input  pc,
      output taken
   );

endinterface

`default_nettype wire

// File: verilog/bp_update_if.sv
`timescale 1ns/1ps
`default_nettype none

// One resolved branch coming back from execute
interface bp_update_if import bp_pkg::*; ();

   logic valid;
   pc_t  pc;
   pc_t  target;
   logic taken;

   modport source (
      output valid,
      output pc,
      output target,
      output taken
   );

   // Both prediction tables only listen
   modport tables (
      input valid,
      input pc,
      input target,
      input taken
   );

endinterface

`default_nettype wire

// File: verilog/btb.sv
`timescale 1ns/1ps
`default_nettype none

module btb import bp_pkg::*; #(
   parameter int idx_len = 4
) (
   input logic           clock,
   input logic           reset,
   bp_lookup_if.btb_side rd0,
   bp_lookup_if.btb_side rd1,
   bp_update_if.tables   wr0,
   bp_update_if.tables   wr1
);

   localparam int tw    = tag_width(idx_len);
   localparam int depth = table_depth(idx_len);

   // Direct mapped storage
   logic [depth-1:0]    valid_q;
   logic [tw-1:0]       tag_mem [depth];
   logic [tgt_bits-1:0] tgt_mem [depth];

   function automatic logic [idx_len-1:0] index_of(input pc_t pc);
      return pc[addr_lo +: idx_len];
   endfunction

   function automatic logic [tw-1:0] tag_of(input pc_t pc);
      return pc[addr_hi -: tw];
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Read ports
   //////////////////////////////////////////////////////////////////////

   logic [idx_len-1:0] rd0_idx;
   logic [idx_len-1:0] rd1_idx;
   logic               rd0_hit;
   logic               rd1_hit;

   assign rd0_idx = index_of(rd0.pc);
   assign rd1_idx = index_of(rd1.pc);

   assign rd0_hit = rd0.en && valid_q[rd0_idx] && (tag_mem[rd0_idx] == tag_of(rd0.pc));
   assign rd1_hit = rd1.en && valid_q[rd1_idx] && (tag_mem[rd1_idx] == tag_of(rd1.pc));

   assign rd0.hit    = rd0_hit;
   assign rd1.hit    = rd1_hit;
   // Miss returns zero
   assign rd0.target = rd0_hit ? expand_target(tgt_mem[rd0_idx]) : '0;
   assign rd1.target = rd1_hit ? expand_target(tgt_mem[rd1_idx]) : '0;

   //////////////////////////////////////////////////////////////////////
   // Write ports
   //////////////////////////////////////////////////////////////////////

   logic [idx_len-1:0] wr0_idx;
   logic [idx_len-1:0] wr1_idx;
   logic               wr0_en;
   logic               wr1_en;

   assign wr0_idx = index_of(wr0.pc);
   assign wr1_idx = index_of(wr1.pc);

   // Only taken branches allocate
   assign wr0_en = wr0.valid && wr0.taken;
   // Slot 0 wins a same index collision
   assign wr1_en = wr1.valid && wr1.taken && !(wr0_en && (wr1_idx == wr0_idx));

   always_ff @(posedge clock) begin
      if (reset) begin
         valid_q <= '0;
      end else begin
         if (wr0_en) begin
            valid_q[wr0_idx] <= 1'b1;
         end
         if (wr1_en) begin
            valid_q[wr1_idx] <= 1'b1;
         end
      end
   end

   // Tag and target payload
   always_ff @(posedge clock) begin
      if (wr0_en) begin
         tag_mem[wr0_idx] <= tag_of(wr0.pc);
         tgt_mem[wr0_idx] <= compress_target(wr0.target);
      end
      if (wr1_en) begin
         tag_mem[wr1_idx] <= tag_of(wr1.pc);
         tgt_mem[wr1_idx] <= compress_target(wr1.target);
      end
   end

endmodule

`default_nettype wire

// File: verilog/bimodal_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module bimodal_predictor import bp_pkg::*; #(
   parameter int idx_len = 4
) (
   input logic           clock,
   input logic           reset,
   bp_lookup_if.dir_side rd0,
   bp_lookup_if.dir_side rd1,
   bp_update_if.tables   up0,
   bp_update_if.tables   up1
);

   localparam int depth = table_depth(idx_len);

   // One untagged counter per index so aliases share it
   ctr_state_e ctr_q [depth];

   function automatic logic [idx_len-1:0] index_of(input pc_t pc);
      return pc[addr_lo +: idx_len];
   endfunction

   // Saturating step up on taken, down otherwise
   function automatic ctr_state_e train(input ctr_state_e state, input logic taken);
      ctr_state_e nxt;
      case (state)
         strong_not_taken: nxt = taken ? weak_not_taken : strong_not_taken;
         weak_not_taken:   nxt = taken ? weak_taken     : strong_not_taken;
         weak_taken:       nxt = taken ? strong_taken   : weak_not_taken;
         strong_taken:     nxt = taken ? strong_taken   : weak_taken;
      endcase
      return nxt;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Direction lookup
   //////////////////////////////////////////////////////////////////////

   ctr_state_e rd0_state;
   ctr_state_e rd1_state;

   assign rd0_state = ctr_q[index_of(rd0.pc)];
   assign rd1_state = ctr_q[index_of(rd1.pc)];

   assign rd0.taken = rd0.en && rd0_state[1];
   assign rd1.taken = rd1.en && rd1_state[1];

   //////////////////////////////////////////////////////////////////////
   // Training
   //////////////////////////////////////////////////////////////////////

   logic [idx_len-1:0] up0_idx;
   logic [idx_len-1:0] up1_idx;
   logic               up1_en;

   assign up0_idx = index_of(up0.pc);
   assign up1_idx = index_of(up1.pc);
   assign up1_en  = up1.valid && !(up0.valid && (up1_idx == up0_idx));

   always_ff @(posedge clock) begin
      if (reset) begin
         for (int i = 0; i < depth; i++) begin
            ctr_q[i] <= weak_not_taken;
         end
      end else begin
         if (up0.valid) begin
            ctr_q[up0_idx] <= train(ctr_q[up0_idx], up0.taken);
         end
         if (up1_en) begin
            ctr_q[up1_idx] <= train(ctr_q[up1_idx], up1.taken);
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/next_pc_select.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc_select import bp_pkg::*; (
   input  logic           fetch_en,
   input  pc_t            fetch_pc,
   bp_lookup_if.requester lk0,
   bp_lookup_if.requester lk1,
   output pc_t            next_pc,
   output logic [1:0]     predict_taken,
   output logic           predict_slot
);

   // Two 4 byte instructions per fetch
   localparam pc_t slot_bytes  = pc_t'(4);
   localparam pc_t fetch_bytes = pc_t'(8);

   logic [1:0] slot_taken;

   //////////////////////////////////////////////////////////////////////
   // Slot addresses
   //////////////////////////////////////////////////////////////////////

   assign lk0.en = fetch_en;
   assign lk1.en = fetch_en;
   assign lk0.pc = fetch_pc;
   assign lk1.pc = fetch_pc + slot_bytes;

   //////////////////////////////////////////////////////////////////////
   // Redirect choice
   //////////////////////////////////////////////////////////////////////

   // Needs both a target and a taken guess
   assign slot_taken[0] = lk0.hit && lk0.taken;
   assign slot_taken[1] = lk1.hit && lk1.taken;

   assign predict_taken = slot_taken;

   // Earliest taken slot in program order wins
   always_comb begin
      if (slot_taken[0]) begin
         next_pc      = lk0.target;
         predict_slot = 1'b0;
      end else if (slot_taken[1]) begin
         next_pc      = lk1.target;
         predict_slot = 1'b1;
      end else begin
         next_pc      = fetch_pc + fetch_bytes;
         predict_slot = 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: verilog/branch_predictor_top.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_top import bp_pkg::*; #(
   parameter int idx_len = 4
) (
   input  logic       clock,
   input  logic       reset,

   // Fetch side
   input  logic       fetch_en,
   input  pc_t        fetch_pc,

   // Resolved branch, slot 0
   input  logic       update_valid_0,
   input  pc_t        update_pc_0,
   input  pc_t        update_target_0,
   input  logic       update_taken_0,

   // Resolved branch, slot 1
   input  logic       update_valid_1,
   input  pc_t        update_pc_1,
   input  pc_t        update_target_1,
   input  logic       update_taken_1,

   // Prediction
   output pc_t        next_pc,
   output logic [1:0] predict_taken,
   output logic       predict_slot
);

   bp_lookup_if lk0 ();
   bp_lookup_if lk1 ();
   bp_update_if up0 ();
   bp_update_if up1 ();

   //////////////////////////////////////////////////////////////////////
   // Update ports onto the update buses
   //////////////////////////////////////////////////////////////////////

   assign up0.valid  = update_valid_0;
   assign up0.pc     = update_pc_0;
   assign up0.target = update_target_0;
   assign up0.taken  = update_taken_0;

   assign up1.valid  = update_valid_1;
   assign up1.pc     = update_pc_1;
   assign up1.target = update_target_1;
   assign up1.taken  = update_taken_1;

   //////////////////////////////////////////////////////////////////////
   // Blocks
   //////////////////////////////////////////////////////////////////////

   btb #(
      .idx_len (idx_len)
   ) u_btb (
      .clock (clock),
      .reset (reset),
      .rd0   (lk0),
      .rd1   (lk1),
      .wr0   (up0),
      .wr1   (up1)
   );

   bimodal_predictor #(
      .idx_len (idx_len)
   ) u_bimodal (
      .clock (clock),
      .reset (reset),
      .rd0   (lk0),
      .rd1   (lk1),
      .up0   (up0),
      .up1   (up1)
   );

   next_pc_select u_next_pc (
      .fetch_en      (fetch_en),
      .fetch_pc      (fetch_pc),
      .lk0           (lk0),
      .lk1           (lk1),
      .next_pc       (next_pc),
      .predict_taken (predict_taken),
      .predict_slot  (predict_slot)
   );

endmodule

`default_nettype wire

// File: dv/branch_predictor_tb.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_tb import bp_pkg::*; ();

   localparam int idx_len         = 4;
   localparam int depth           = 1 << idx_len;
   localparam int tw              = tag_width(idx_len);
   localparam int reset_cycles    = 3;
   localparam int directed_cycles = 60;
   localparam int random_cycles   = 2000;
   // Twice the total test length
   localparam int timeout_cycles  = 2 * (reset_cycles + directed_cycles + random_cycles);

   logic clock, reset, fetch_en;
   pc_t  fetch_pc;
   logic update_valid_0, update_taken_0, update_valid_1, update_taken_1;
   pc_t  update_pc_0, update_target_0, update_pc_1, update_target_1;
   pc_t        next_pc;
   logic [1:0] predict_taken;
   logic       predict_slot;

   // Reference model of both tables
   logic [depth-1:0]  ref_valid;
   logic [tw-1:0]     ref_tag [depth];
   logic [13:0]       ref_tgt [depth];
   ctr_state_e        ref_ctr [depth];

   logic [31:0] lfsr_state;
   string       test_name = "reset";
   int          test_errors = 0, error_count = 0, check_count = 0;
   int          tests_run = 0, tests_failed = 0, cycle_count = 0;

   branch_predictor_top #(.idx_len(idx_len)) DUT (.*);

   initial begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   ////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////

   // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      logic        fb;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         bits = {bits[30:0], fb};
      end
      return bits;
   endfunction

   // Four tags per index so random traffic hits often
   function automatic pc_t rand_addr();
      logic [31:0] upper;
      logic [31:0] tag_sel;
      logic [31:0] idx;
      upper   = take_bits(16);
      tag_sel = take_bits(2);
      idx     = take_bits(4);
      return {upper[15:0], tag_sel[1:0], 8'h00, idx[3:0], 2'b00};
   endfunction

   task automatic drive_fetch(input logic en, input pc_t pc);
      fetch_en <= en;
      fetch_pc <= pc;
   endtask

   task automatic drive_update(input int slot, input logic valid, input pc_t pc,
                               input pc_t target, input logic taken);
      if (slot == 0) begin
         update_valid_0  <= valid;
         update_pc_0     <= pc;
         update_target_0 <= target;
         update_taken_0  <= taken;
      end else begin
         update_valid_1  <= valid;
         update_pc_1     <= pc;
         update_target_1 <= target;
         update_taken_1  <= taken;
      end
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      @(posedge clock);
      tests_run++;
      if (test_errors != 0) begin
         tests_failed++;
      end
      $display("%s finished with %0d errors", test_name, test_errors);
   endtask

   ////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////

   function automatic logic [idx_len-1:0] index_of(input pc_t pc);
      return pc[idx_len+1:2];
   endfunction

   function automatic logic [tw-1:0] tag_of(input pc_t pc);
      return pc[15:idx_len+2];
   endfunction

   function automatic ctr_state_e step_counter(input ctr_state_e s, input logic taken);
      if (taken) begin
         return (s == strong_taken) ? s : ctr_state_e'(s + 2'd1);
      end else begin
         return (s == strong_not_taken) ? s : ctr_state_e'(s - 2'd1);
      end
   endfunction

   function automatic void expect_prediction(input logic en, input pc_t pc,
      output pc_t npc, output logic [1:0] tk, output logic slot);
      logic [idx_len-1:0] i0;
      logic [idx_len-1:0] i1;
      i0 = index_of(pc);
      i1 = index_of(pc + 32'd4);
      tk[0] = en && ref_valid[i0] && ref_tag[i0] == tag_of(pc) && ref_ctr[i0] >= weak_taken;
      tk[1] = en && ref_valid[i1] && ref_tag[i1] == tag_of(pc + 32'd4)
              && ref_ctr[i1] >= weak_taken;
      slot = !tk[0] && tk[1];
      if (tk[0]) begin
         npc = {16'h0000, ref_tgt[i0], 2'b00};
      end else if (tk[1]) begin
         npc = {16'h0000, ref_tgt[i1], 2'b00};
      end else begin
         npc = pc + 32'd8;
      end
   endfunction

   task automatic apply_updates();
      logic [idx_len-1:0] i0;
      logic [idx_len-1:0] i1;
      ctr_state_e         n0;
      ctr_state_e         n1;
      i0 = index_of(update_pc_0);
      i1 = index_of(update_pc_1);
      n0 = step_counter(ref_ctr[i0], update_taken_0);
      n1 = step_counter(ref_ctr[i1], update_taken_1);
      if (update_valid_1 && update_taken_1 && !(update_valid_0 && update_taken_0 && i1 == i0)) begin
         ref_valid[i1] = 1'b1;
         ref_tag[i1]   = tag_of(update_pc_1);
         ref_tgt[i1]   = update_target_1[15:2];
      end
      // Slot 0 written last so it wins
      if (update_valid_0 && update_taken_0) begin
         ref_valid[i0] = 1'b1;
         ref_tag[i0]   = tag_of(update_pc_0);
         ref_tgt[i0]   = update_target_0[15:2];
      end
      if (update_valid_1 && !(update_valid_0 && i1 == i0)) begin
         ref_ctr[i1] = n1;
      end
      if (update_valid_0) begin
         ref_ctr[i0] = n0;
      end
   endtask

   ////////////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////////////

   task automatic compare_pc(input string name, input pc_t exp, input pc_t act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         test_errors++;
         $display("Error %s next_pc: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic compare_taken(input string name, input logic [1:0] exp, input logic [1:0] act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         test_errors++;
         $display("Error %s predict_taken: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic compare_slot(input string name, input logic exp, input logic act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         test_errors++;
         $display("Error %s predict_slot: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic compare_state(input string name, input ctr_state_e exp, input ctr_state_e act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         test_errors++;
         $display("Error %s counter: expected %s, actual %s", name, exp.name(), act.name());
      end
   endtask

   // Checks each cycle just before the next rising edge
   initial begin
      pc_t        exp_pc;
      logic [1:0] exp_tk;
      logic       exp_slot;
      forever begin
         @(posedge clock);
         #8;
         if (reset) begin
            ref_valid = '0;
            for (int i = 0; i < depth; i++) begin
               ref_ctr[i] = weak_not_taken;
            end
         end else begin
            expect_prediction(fetch_en, fetch_pc, exp_pc, exp_tk, exp_slot);
            compare_pc(test_name, exp_pc, next_pc);
            compare_taken(test_name, exp_tk, predict_taken);
            if (exp_tk != 2'b00) begin
               compare_slot(test_name, exp_slot, predict_slot);
            end
            apply_updates();
         end
      end
   end

   initial begin
      while (cycle_count < timeout_cycles) begin
         @(posedge clock);
         cycle_count++;
      end
      $display("Timeout after %0d cycles, the tests never finished", cycle_count);
      $display("sim failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////////////

   initial begin
      pc_t         pc;
      logic [31:0] r;
      logic        v;
      logic        k;
      lfsr_state = 32'h61ac_8622;
      reset <= 1'b1;
      drive_fetch(1'b0, '0);
      drive_update(0, 1'b0, '0, '0, 1'b0);
      drive_update(1, 1'b0, '0, '0, 1'b0);
      repeat (reset_cycles) @(posedge clock);
      reset <= 1'b0;

      begin_test("reset_state");
      repeat (20) begin
         @(posedge clock);
         pc = take_bits(32);
         drive_fetch(1'b1, pc);
         #5;
         compare_taken(test_name, 2'b00, predict_taken);
         compare_pc(test_name, pc + 32'd8, next_pc);
      end
      end_test();

      begin_test("train_and_hit");
      drive_fetch(1'b0, '0);
      drive_update(0, 1'b1, 32'h0000_1234, 32'hdead_beef, 1'b1);
      @(posedge clock);
      #1 compare_state(test_name, weak_taken, DUT.u_bimodal.ctr_q[index_of(32'h0000_1234)]);
      @(posedge clock);
      drive_update(0, 1'b0, '0, '0, 1'b0);
      #1 compare_state(test_name, strong_taken, DUT.u_bimodal.ctr_q[index_of(32'h0000_1234)]);
      @(posedge clock);
      drive_fetch(1'b1, 32'h0000_1234);
      #5 compare_pc(test_name, 32'h0000_beec, next_pc);
      @(posedge clock);
      drive_fetch(1'b1, 32'h0000_1230);
      #5 compare_slot(test_name, 1'b1, predict_slot);
      compare_pc(test_name, 32'h0000_beec, next_pc);
      end_test();

      // Same index as above with tag bit 14 flipped
      begin_test("alias_miss");
      drive_fetch(1'b1, 32'h0000_5234);
      #5 compare_taken(test_name, 2'b00, predict_taken);
      @(posedge clock);
      drive_update(0, 1'b1, 32'h0000_5234, '0, 1'b0);
      repeat (2) @(posedge clock);
      drive_update(0, 1'b0, '0, '0, 1'b0);
      drive_fetch(1'b1, 32'h0000_1234);
      #5 compare_taken(test_name, 2'b00, predict_taken);
      compare_pc(test_name, 32'h0000_123c, next_pc);
      end_test();

      begin_test("same_index");
      drive_update(0, 1'b1, 32'h0000_0100, 32'h1111_2222, 1'b1);
      drive_update(1, 1'b1, 32'h0000_8100, 32'h3333_4444, 1'b1);
      @(posedge clock);
      drive_update(0, 1'b0, '0, '0, 1'b0);
      drive_update(1, 1'b0, '0, '0, 1'b0);
      drive_fetch(1'b1, 32'h0000_0100);
      #1 compare_state(test_name, weak_taken, DUT.u_bimodal.ctr_q[0]);
      #4 compare_pc(test_name, 32'h0000_2220, next_pc);
      @(posedge clock);
      drive_fetch(1'b1, 32'h0000_8100);
      #5 compare_taken(test_name, 2'b00, predict_taken);
      end_test();

      begin_test("dual_hit");
      drive_update(0, 1'b1, 32'h0000_0228, 32'h0000_0a00, 1'b1);
      drive_update(1, 1'b1, 32'h0000_022c, 32'h0000_0b00, 1'b1);
      @(posedge clock);
      drive_update(0, 1'b0, '0, '0, 1'b0);
      drive_update(1, 1'b0, '0, '0, 1'b0);
      drive_fetch(1'b1, 32'h0000_0228);
      #5 compare_taken(test_name, 2'b11, predict_taken);
      compare_slot(test_name, 1'b0, predict_slot);
      compare_pc(test_name, 32'h0000_0a00, next_pc);
      @(posedge clock);
      drive_fetch(1'b0, 32'h0000_0228);
      #5 compare_taken(test_name, 2'b00, predict_taken);
      end_test();

      begin_test("random_mix");
      repeat (random_cycles) begin
         @(posedge clock);
         r = take_bits(2);
         drive_fetch(r != 0, rand_addr());
         for (int s = 0; s < 2; s++) begin
            r = take_bits(1);
            v = (r != 0);
            r = take_bits(2);
            k = (r != 0);
            pc = rand_addr();
            drive_update(s, v, pc, take_bits(32), k);
         end
      end
      end_test();

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, check_count, error_count);
      if (error_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
verilog/bp_pkg.sv
verilog/bp_lookup_if.sv
verilog/bp_update_if.sv
verilog/btb.sv
verilog/bimodal_predictor.sv
verilog/next_pc_select.sv
verilog/branch_predictor_top.sv
dv/branch_predictor_tb.sv

// File: Makefile
# Verilator flow for the branch predictor

VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= branch_predictor_tb
RTL_TOP   ?= branch_predictor_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= sim failed
JOBS      ?= 0
VFLAGS    ?= --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# A crash of the binary also counts as a failing run
sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
